/* design/vecPkg.sv */
/*
  Vector engine shared definitions
  Word, address and length widths, opcode and controller state encodings
*/
package vecPkg;

  // ==========================================================
  // Default widths
  // ==========================================================
  localparam int DATA_W = 32;  // Bits per RAM word
  localparam int ADDR_W = 8;   // 256-word scratchpad
  localparam int LEN_W  = 9;   // Room for a full 256-element run

  typedef logic [DATA_W-1:0] dataT;  // One RAM word
  typedef logic [ADDR_W-1:0] addrT;  // RAM word address
  typedef logic [LEN_W-1:0]  lenT;   // Element count

  // ==========================================================
  // Encodings
  // ==========================================================
  typedef enum logic [1:0] {
    opAdd = 2'd0,
    opSub = 2'd1,
    opXor = 2'd2
  } vecOpT;

  // Controller only
  typedef enum logic [1:0] {
    sIdle  = 2'd0,
    sRun   = 2'd1,
    sDrain = 2'd2,
    sDone  = 2'd3
  } ctrlStateT;

endpackage

/* design/twoPortBram.sv */
/*
  Two-port block RAM with two read and two write ports
  Registered reads forward same-cycle write data, port 0 first
  Port 0 alone writes when both write ports hit one address
*/
`timescale 1ns/1ns
module twoPortBram #(
  parameter int DataWidth = 32,
  parameter int AddrWidth = 8
) (
  input  logic         clock,
  input  logic         readEnable0,
  input  vecPkg::addrT readAddress0,
  output vecPkg::dataT readData0,
  input  logic         readEnable1,
  input  vecPkg::addrT readAddress1,
  output vecPkg::dataT readData1,
  input  logic         writeEnable0,
  input  vecPkg::addrT writeAddress0,
  input  vecPkg::dataT writeData0,
  input  logic         writeEnable1,
  input  vecPkg::addrT writeAddress1,
  input  vecPkg::dataT writeData1
);

  localparam int Depth = 1 << AddrWidth;

  logic [DataWidth-1:0] mem [0:Depth-1];  // Storage array

  // Read value for one port, forwarding included
  function automatic logic [DataWidth-1:0] readPick(input logic en,
                                                    input logic [AddrWidth-1:0] addr);
    if (!en) begin
      return '0;                                    // Idle port reads as zero
    end else if (writeEnable0 && addr == writeAddress0) begin
      return writeData0;                            // Port 0 takes priority
    end else if (writeEnable1 && addr == writeAddress1) begin
      return writeData1;
    end
    return mem[addr];
  endfunction

  // ==========================================================
  // Registered reads
  // ==========================================================
  always_ff @(posedge clock) begin
    readData0 <= readPick(readEnable0, readAddress0);
    readData1 <= readPick(readEnable1, readAddress1);
  end

  // ==========================================================
  // Writes
  // ==========================================================
  always @(posedge clock) begin
    if (writeEnable0) begin
      mem[writeAddress0] <= writeData0;
    end
    if (writeEnable1 && !(writeEnable0 && writeAddress1 == writeAddress0)) begin
      mem[writeAddress1] <= writeData1;  // Dropped on a collision
    end
  end

  // Power-up contents all zero
  initial begin
    for (int i = 0; i < Depth; i++) begin
      mem[i] = '0;
    end
  end

endmodule

/* design/vecAddrGen.sv */
/*
  Vector address generator
  Steps the A, B and destination addresses once per issued element
  and delays the destination two cycles to line up with the ALU result
*/
`timescale 1ns/1ns
module vecAddrGen (
  input  logic         clock,
  input  logic         rst,
  input  logic         load,
  input  logic         issue,
  input  vecPkg::addrT baseA,
  input  vecPkg::addrT baseB,
  input  vecPkg::addrT baseDst,
  input  vecPkg::lenT  len,
  output vecPkg::addrT rdAddrA,
  output vecPkg::addrT rdAddrB,
  output vecPkg::addrT wrAddr,
  output logic         lastIssue
);

  import vecPkg::*;

  lenT  count;    // Elements issued so far
  lenT  lenHeld;  // Run length of the current command
  addrT dstAddr;  // Destination of the element now being read
  addrT dstDly;   // One cycle behind dstAddr

  // ==========================================================
  // Element counter
  // ==========================================================
  always_ff @(posedge clock) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= '0;
    end else if (issue) begin
      count <= count + lenT'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      lenHeld <= len;
    end
  end

  assign lastIssue = (count == lenHeld - lenT'(1));  // Final element this cycle

  // ==========================================================
  // Address stepping
  // ==========================================================
  always_ff @(posedge clock) begin
    if (load) begin
      rdAddrA <= baseA;
      rdAddrB <= baseB;
      dstAddr <= baseDst;
    end else if (issue) begin
      rdAddrA <= rdAddrA + addrT'(1);  // Wraps modulo RAM depth
      rdAddrB <= rdAddrB + addrT'(1);
      dstAddr <= dstAddr + addrT'(1);
    end
  end

  // RAM read stage then ALU stage
  always_ff @(posedge clock) begin
    dstDly <= dstAddr;
    wrAddr <= dstDly;
  end

endmodule

/* design/vecAlu.sv */
/*
  Vector ALU
  One registered stage of add, subtract or XOR on two RAM words
*/
`timescale 1ns/1ns
module vecAlu (
  input  logic          clock,
  input  vecPkg::vecOpT op,
  input  vecPkg::dataT  opA,
  input  vecPkg::dataT  opB,
  output vecPkg::dataT  result
);

  import vecPkg::*;

  // ==========================================================
  // Result register
  // ==========================================================
  // op is held by the controller for the whole run,
  // so no per-element opcode pipeline is needed here
  always_ff @(posedge clock) begin
    case (op)
      opAdd: begin
        result <= opA + opB;  // Wraps at word width
      end
      opSub: begin
        result <= opA - opB;  // Two's complement difference
      end
      opXor: begin
        result <= opA ^ opB;
      end
      default: begin
        result <= opA;        // Unused code passes A through
      end
    endcase
  end

endmodule

/* design/vecCtrl.sv */
/*
  Vector engine controller
  Runs idle, run, drain and done states, tracks in-flight elements
  and hands RAM port 1 to the host whenever no command runs
*/
`timescale 1ns/1ns
module vecCtrl (
  input  logic          clock,
  input  logic          rst,
  input  logic          start,
  input  vecPkg::vecOpT opIn,
  input  logic          hostRdEn,
  input  logic          hostWrEn,
  input  vecPkg::addrT  hostAddr,
  input  logic          lastIssue,
  input  vecPkg::addrT  rdAddrB,
  output vecPkg::vecOpT opHeld,
  output logic          load,
  output logic          issue,
  output logic          busy,
  output logic          done,
  output logic          readEnable0,
  output logic          readEnable1,
  output logic          writeEnable0,
  output logic          writeEnable1,
  output vecPkg::addrT  readAddress1
);

  import vecPkg::*;

  ctrlStateT state;
  ctrlStateT stateNext;
  logic      validD1;  // Element in RAM read stage
  logic      validD2;  // Element in ALU stage, written this cycle

  // ==========================================================
  // State machine
  // ==========================================================
  always_comb begin
    stateNext = state;
    case (state)
      sIdle: begin
        if (start) begin
          stateNext = sRun;
        end
      end
      sRun: begin
        if (lastIssue) begin
          stateNext = sDrain;
        end
      end
      sDrain: begin
        if (validD2 && !validD1) begin
          stateNext = sDone;  // Last write lands at this edge
        end
      end
      default: begin
        stateNext = sIdle;    // sDone lasts one cycle
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state   <= sIdle;
      validD1 <= 1'b0;
      validD2 <= 1'b0;
      opHeld  <= opAdd;
    end else begin
      state   <= stateNext;
      validD1 <= issue;
      validD2 <= validD1;
      if (load) begin
        opHeld <= opIn;  // Stable for the whole command
      end
    end
  end

  assign load  = (state == sIdle) && start;  // Start outside idle is dropped
  assign issue = (state == sRun);
  assign busy  = (state == sRun) || (state == sDrain);
  assign done  = (state == sDone);

  // ==========================================================
  // RAM port steering
  // ==========================================================
  assign readEnable0  = issue;
  assign writeEnable0 = validD2;
  assign readEnable1  = busy ? issue : hostRdEn;  // Host gated off while busy
  assign readAddress1 = busy ? rdAddrB : hostAddr;
  assign writeEnable1 = !busy && hostWrEn;

endmodule

/* design/vecEngine.sv */
/*
  Vector engine top level
  Controller, address generator and ALU around a two-port scratchpad RAM
  Host loads and reads words between commands
*/
`timescale 1ns/1ns
module vecEngine #(
  parameter int DataWidth = vecPkg::DATA_W,
  parameter int AddrWidth = vecPkg::ADDR_W
) (
  input  logic          clock,
  input  logic          rst,
  input  logic          hostWrEn,
  input  logic          hostRdEn,
  input  vecPkg::addrT  hostAddr,
  input  vecPkg::dataT  hostWrData,
  output vecPkg::dataT  hostRdData,
  input  logic          start,
  input  vecPkg::vecOpT op,
  input  vecPkg::addrT  baseA,
  input  vecPkg::addrT  baseB,
  input  vecPkg::addrT  baseDst,
  input  vecPkg::lenT   len,
  output logic          busy,
  output logic          done
);

  import vecPkg::*;

  vecOpT opHeld;       // Latched opcode to the ALU
  logic  load;
  logic  issue;
  logic  lastIssue;
  addrT  rdAddrA;
  addrT  rdAddrB;
  addrT  wrAddr;       // Destination aligned with aluResult
  addrT  readAddress1;
  logic  readEnable0;
  logic  readEnable1;
  logic  writeEnable0;
  logic  writeEnable1;
  dataT  readData0;    // Operand A
  dataT  aluResult;

  // ==========================================================
  // Control
  // ==========================================================
  vecCtrl uCtrl (
    .clock        (clock),
    .rst          (rst),
    .start        (start),
    .opIn         (op),
    .hostRdEn     (hostRdEn),
    .hostWrEn     (hostWrEn),
    .hostAddr     (hostAddr),
    .lastIssue    (lastIssue),
    .rdAddrB      (rdAddrB),
    .opHeld       (opHeld),
    .load         (load),
    .issue        (issue),
    .busy         (busy),
    .done         (done),
    .readEnable0  (readEnable0),
    .readEnable1  (readEnable1),
    .writeEnable0 (writeEnable0),
    .writeEnable1 (writeEnable1),
    .readAddress1 (readAddress1)
  );

  vecAddrGen uAddrGen (
    .clock     (clock),
    .rst       (rst),
    .load      (load),
    .issue     (issue),
    .baseA     (baseA),
    .baseB     (baseB),
    .baseDst   (baseDst),
    .len       (len),
    .rdAddrA   (rdAddrA),
    .rdAddrB   (rdAddrB),
    .wrAddr    (wrAddr),
    .lastIssue (lastIssue)
  );

  // ==========================================================
  // Datapath
  // ==========================================================
  vecAlu uAlu (
    .clock  (clock),
    .op     (opHeld),
    .opA    (readData0),
    .opB    (hostRdData),  // Read port 1 carries operand B while running
    .result (aluResult)
  );

  twoPortBram #(
    .DataWidth (DataWidth),
    .AddrWidth (AddrWidth)
  ) uBram (
    .clock         (clock),
    .readEnable0   (readEnable0),
    .readAddress0  (rdAddrA),
    .readData0     (readData0),
    .readEnable1   (readEnable1),
    .readAddress1  (readAddress1),
    .readData1     (hostRdData),  // Shared by host reads and operand B
    .writeEnable0  (writeEnable0),
    .writeAddress0 (wrAddr),
    .writeData0    (aluResult),
    .writeEnable1  (writeEnable1),
    .writeAddress1 (hostAddr),    // Host writes straight in
    .writeData1    (hostWrData)
  );

endmodule

/* sim/vecEngine_sva.sv */
/*
  Controller timing checks
  Done pulse width, busy release, write enables after reset and in idle
*/
`timescale 1ns/1ns
module vecCtrlChecks (
  input logic              clock,
  input logic              rst,
  input logic              busy,
  input logic              done,
  input logic              writeEnable0,
  input logic              writeEnable1,
  input vecPkg::ctrlStateT state
);

  import vecPkg::*;

  // ==========================================================
  // Command completion
  // ==========================================================
  donePulse: assert property (@(posedge clock) disable iff (rst) done |=> !done)
    else $error("done high for more than one cycle");

  busyDropsWithDone: assert property (@(posedge clock) disable iff (rst)
    $rose(done) |-> $fell(busy))
    else $error("busy did not fall as done rose");

  doneWithBusyDrop: assert property (@(posedge clock) disable iff (rst)
    $fell(busy) |-> $rose(done))
    else $error("busy fell without done");

  // ==========================================================
  // Write enables
  // ==========================================================
  quietAfterReset: assert property (@(posedge clock)
    $fell(rst) |-> !writeEnable0 && !writeEnable1)
    else $error("write enable high right after reset");

  noEngineWriteIdle: assert property (@(posedge clock) disable iff (rst)
    (state == sIdle) |-> !writeEnable0)  // Engine port only in a command
    else $error("writeEnable0 high while idle");

endmodule

bind vecCtrl vecCtrlChecks uCtrlChecks (
  .clock        (clock),
  .rst          (rst),
  .busy         (busy),
  .done         (done),
  .writeEnable0 (writeEnable0),
  .writeEnable1 (writeEnable1),
  .state        (state)
);

/* sim/vecEngineTb.sv */
/*
  Vector engine testbench
  Replays the stimulus file against the DUT and a reference memory model,
  checks read data, done timing and busy gating
*/
`timescale 1ns/1ns
module vecEngineTb;

  import vecPkg::*;

  localparam string StimFile = "sim/vecStim.txt";
  localparam int    Depth    = 256;

  logic  clock;
  logic  rst;
  logic  hostWrEn;
  logic  hostRdEn;
  addrT  hostAddr;
  dataT  hostWrData;
  dataT  hostRdData;
  logic  start;
  vecOpT op;
  addrT  baseA;
  addrT  baseB;
  addrT  baseDst;
  lenT   len;
  logic  busy;
  logic  done;

  dataT        model [0:Depth-1];  // Expected RAM contents
  string       lines [$];          // Stimulus file, one entry per line
  logic [31:0] rngState;
  int          testErrors;         // Errors in the running test
  int          passCount;
  int          failCount;
  int          budget;             // Watchdog limit in cycles
  logic        budgetReady;

  vecEngine u_dut (
    .clock      (clock),
    .rst        (rst),
    .hostWrEn   (hostWrEn),
    .hostRdEn   (hostRdEn),
    .hostAddr   (hostAddr),
    .hostWrData (hostWrData),
    .hostRdData (hostRdData),
    .start      (start),
    .op         (op),
    .baseA      (baseA),
    .baseB      (baseB),
    .baseDst    (baseDst),
    .len        (len),
    .busy       (busy),
    .done       (done)
  );

  always #50 clock = ~clock;  // 100 ns period

  // ==========================================================
  // Reference helpers
  // ==========================================================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic dataT aluRef(input int code, input dataT a, input dataT b);
    case (code)
      0: return a + b;
      1: return a - b;
      default: return a ^ b;
    endcase
  endfunction

  // Element order, each write seen two elements later
  task automatic runModel(input int code, input int a, input int b, input int d, input int n);
    dataT res [0:Depth-1];
    for (int i = 0; i < n; i++) begin
      if (i >= 2) begin
        model[(d + i - 2) % Depth] = res[i-2];
      end
      res[i] = aluRef(code, model[(a + i) % Depth], model[(b + i) % Depth]);
    end
    for (int i = (n >= 2) ? n - 2 : 0; i < n; i++) begin
      model[(d + i) % Depth] = res[i];  // Last two still in flight
    end
  endtask

  task automatic reportMismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    testErrors++;
  endtask

  task automatic reportFailure(input string msg);
    $display("failure at %0t: %s", $time, msg);
    testErrors++;
  endtask

  // ==========================================================
  // Bus actions, all driven on the falling edge
  // ==========================================================
  task automatic hostWrite(input int a, input dataT d);
    @(negedge clock);
    hostWrEn   = 1'b1;
    hostAddr   = addrT'(a);
    hostWrData = d;
    @(negedge clock);
    hostWrEn = 1'b0;
    model[a % Depth] = d;
  endtask

  task automatic checkRead(input int a, input dataT expected);
    @(negedge clock);
    hostRdEn = 1'b1;
    hostAddr = addrT'(a);
    @(negedge clock);
    hostRdEn = 1'b0;  // Data registered at the edge just passed
    if (hostRdData !== expected) begin
      reportMismatch($sformatf("addr %02h expected %08h got %08h", a, expected, hostRdData));
    end
  endtask

  task automatic runCommand(input int code, input int a, input int b, input int d, input int n);
    int   cycles;
    logic seenDone;
    runModel(code, a, b, d, n);
    @(negedge clock);
    start   = 1'b1;
    op      = vecOpT'(code);
    baseA   = addrT'(a);
    baseB   = addrT'(b);
    baseDst = addrT'(d);
    len     = lenT'(n);
    cycles   = 0;
    seenDone = 1'b0;
    while (!seenDone && cycles < n + 10) begin
      @(negedge clock);
      cycles++;
      start    = 1'b0;
      hostWrEn = 1'b0;
      hostRdEn = 1'b0;
      if (cycles == n + 3 && hostRdData !== '0) begin
        reportMismatch($sformatf("host read while busy returned %08h", hostRdData));
      end
      if (done) begin
        seenDone = 1'b1;
        if (cycles != n + 3) begin
          reportMismatch($sformatf("done after %0d cycles, expected %0d", cycles, n + 3));
        end
        if (busy) begin
          reportMismatch("busy still high with done");
        end
      end else if (!busy) begin
        reportMismatch($sformatf("busy low %0d cycles after start", cycles));
      end
      if (cycles == 2) begin  // Second start, must be dropped
        start   = 1'b1;
        op      = vecOpT'((code + 1) % 3);
        baseDst = addrT'(d ^ 8'h55);
        len     = lenT'(3);
      end
      if (cycles == n + 2) begin  // Last drain cycle
        hostWrEn   = 1'b1;
        hostRdEn   = 1'b1;
        hostAddr   = addrT'(b);
        hostWrData = ~model[b % Depth];
      end
    end
    if (!seenDone) begin
      reportFailure($sformatf("done never came within %0d cycles of start", cycles));
    end
  endtask

  // ==========================================================
  // Stimulus file
  // ==========================================================
  task automatic loadStimulus();
    int    fd;
    int    n;
    int    f [0:4];
    string line;
    budget = 10;  // Reset and closing
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      reportFailure("cannot open the stimulus file");
    end else begin
      while ($fgets(line, fd) > 0) begin
        lines.push_back(line);
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4]);
        budget += 20;
        if (line.getc(0) == "C" && n == 5) begin
          budget += f[4];
        end else if (line.getc(0) == "F" && n == 2) begin
          budget += 2 * f[1];  // Two cycles per host write
        end
      end
      $fclose(fd);
    end
    budgetReady = 1'b1;
  endtask

  task automatic runStimulus();
    int    n;
    int    testNum;
    int    f [0:4];
    byte   kind;
    string line;
    testNum = 0;
    foreach (lines[i]) begin
      line = lines[i];
      kind = line.getc(0);
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4]);
      case (kind)
        "W": hostWrite(f[0], dataT'(f[1]));
        "F": begin
          for (int k = 0; k < f[1]; k++) begin
            rngState = xorshift(rngState);
            hostWrite((f[0] + k) % Depth, rngState);
          end
        end
        "C": runCommand(f[0], f[1], f[2], f[3], f[4]);
        "R": checkRead(f[0], (n >= 2) ? dataT'(f[1]) : model[f[0] % Depth]);  // Dash takes model
        "T": begin
          testNum++;
          if (testErrors == 0) begin
            passCount++;
            $display("test %0d passed", testNum);
          end else begin
            failCount++;
            $display("test %0d failed with %0d errors", testNum, testErrors);
          end
          testErrors = 0;
        end
        default: ;  // Comment or blank line
      endcase
    end
  endtask

  // ==========================================================
  // Main sequence and watchdog
  // ==========================================================
  initial begin
    clock       = 1'b0;
    rst         = 1'b1;
    hostWrEn    = 1'b0;
    hostRdEn    = 1'b0;
    hostAddr    = '0;
    hostWrData  = '0;
    start       = 1'b0;
    op          = opAdd;
    baseA       = '0;
    baseB       = '0;
    baseDst     = '0;
    len         = '0;
    rngState    = 32'hc28e;
    testErrors  = 0;
    passCount   = 0;
    failCount   = 0;
    budgetReady = 1'b0;
    for (int i = 0; i < Depth; i++) begin
      model[i] = '0;  // RAM powers up cleared
    end
    loadStimulus();
    if (testErrors != 0) begin
      failCount++;
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    runStimulus();
    @(negedge clock);
    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0 && passCount > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    wait (budgetReady);
    repeat (budget) @(posedge clock);
    $display("watchdog expired after %0d cycles", budget);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* sim/vecStim.txt */
# Kind then hex fields: W addr data | F addr count | R addr expected, or - for model | T ends test
# C op baseA baseB baseDst len, op 0 add 1 sub 2 xor
W 05 12345678
W 06 cafef00d
R 05 12345678
R 06 cafef00d
R 07 00000000
T
F 10 10
F 20 10
C 0 10 20 40 10
R 40 -
R 47 -
R 4f -
R 50 -
R 3f -
C 1 10 20 60 8
R 60 -
R 67 -
R 68 -
C 2 10 20 80 4
R 80 -
R 83 -
R 10 -
R 20 -
T
C 0 05 06 90 1
R 90 -
R 91 -
R 06 cafef00d
T
F a0 8
C 0 a0 20 a2 8
R a2 -
R a5 -
R a9 -
R aa -
T
C 2 00 80 03 100
R 03 -
R 02 -
R 80 -
R ff -
T

/* compile.f */
design/vecPkg.sv
design/twoPortBram.sv
design/vecAddrGen.sv
design/vecAlu.sv
design/vecCtrl.sv
design/vecEngine.sv
sim/vecEngine_sva.sv
sim/vecEngineTb.sv

/* Makefile */
# Verilator build and run for the vector engine testbench

TOP = vecEngineTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f compile.f -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir
